// ==== dv/tb_fetch_frontend.sv ====
// testbench for the fetch front end, with a stalling bus model, a decode model and directed tests
`timescale 1ns/1ps

module tb_fetch_frontend import fetch_pkg::*; ();

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
	// odd halfword target, so the first word after the jump loses its low half
	localparam logic [31:0] JUMP_TARGET  = 32'h0000_0302;
	localparam int          N_TESTS      = 5;
	localparam int          WAIT_LIMIT   = 300;

	logic              clk;
	logic              rst_n;
	logic [W_ADDR-1:0] mem_addr;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [W_DATA-1:0] mem_data;
	logic              mem_data_vld;
	logic [W_ADDR-1:0] jump_target;
	logic              jump_vld;
	logic              jump_rdy;
	logic [W_DATA-1:0] cir;
	hw_count_t         cir_vld;
	hw_count_t         cir_use;
	logic [4:0]        predecode_rs1;
	logic [4:0]        predecode_rs2;

	// program image keyed by word address
	logic [31:0] image [logic [31:0]];
	// expected stream, consumed stream and the predecode seen one cycle earlier
	logic [31:0] exp_q [$];
	logic [31:0] tgt_q [$];
	logic [31:0] got_q [$];
	logic [9:0]  got_regs_q [$];
	// accepted addresses, and the bus pipeline with the cycle each word is due
	logic [31:0] acc_log [$];
	logic [31:0] bus_addr_q [$];
	int          bus_due_q [$];

	integer      seed = 32'hf46a_736b;
	int          cyc;
	int          last_due;
	int          returned;
	int          want;
	logic        decode_en;
	logic [9:0]  pd_sample;
	hw_count_t   need_hw;
	int          err_count;
	int          tests_run;
	int          tests_failed;

	fetch_frontend #(
		.RESET_VECTOR(RESET_VECTOR)
	) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data     (mem_data),
		.mem_data_vld (mem_data_vld),
		.jump_target  (jump_target),
		.jump_vld     (jump_vld),
		.jump_rdy     (jump_rdy),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_use      (cir_use),
		.predecode_rs1(predecode_rs1),
		.predecode_rs2(predecode_rs2)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// memory image helpers

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		// every address bit reaches the pattern through the multiply and the swap
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] waddr);
		if (image.exists(waddr)) begin
			return image[waddr];
		end
		return fill_word(waddr);
	endfunction

	task automatic write_half(input logic [31:0] addr, input logic [15:0] hw);
		logic [31:0] waddr;
		logic [31:0] word;
		waddr = {addr[31:2], 2'b00};
		word  = read_word(waddr);
		if (addr[1]) begin
			word[31:16] = hw;
		end else begin
			word[15:0] = hw;
		end
		image[waddr] = word;
	endtask

	// lays out count instructions from base, pct_c percent of them compressed
	task automatic place_program(input logic [31:0] base, input int count, input int pct_c);
		logic [31:0] addr;
		logic [31:0] r;
		logic [1:0]  quad;
		int          roll;
		addr = base;
		for (int i = 0; i < count; i++) begin
			roll = $unsigned($random(seed)) % 100;
			r    = $random(seed);
			if (roll < pct_c) begin
				// any quadrant but 2'b11 marks a 16-bit instruction
				quad = (r[17:16] == 2'b11) ? 2'b01 : r[17:16];
				write_half(addr, {r[15:2], quad});
				exp_q.push_back({16'h0, r[15:2], quad});
				addr = addr + 2;
			end else begin
				// 32-bit instructions may start on either halfword and straddle words
				write_half(addr, {r[15:2], 2'b11});
				write_half(addr + 2, r[31:16]);
				exp_q.push_back({r[31:2], 2'b11});
				addr = addr + 4;
			end
		end
	endtask

	// register numbers that the coarse predecode table gives, packed as {rs1, rs2}
	function automatic logic [9:0] coarse_regs(input logic [31:0] word);
		instr_word_u w;
		logic [4:0]  r1;
		logic [4:0]  r2;
		w  = word;
		r1 = w.i32.rs1;
		r2 = w.i32.rs2;
		if (w.c16.quadrant == 2'b00) begin
			// addi4spn reads the stack pointer, loads and stores use rs1'
			if (w.c16.funct3[2:1] == 2'b00) begin
				r1 = 5'd2;
			end else begin
				r1 = {2'b01, w.c16.rd_rs1.prime};
			end
		end else if (w.c16.quadrant == 2'b01) begin
			r1 = w.c16.rd_rs1;
		end else if (w.c16.quadrant == 2'b10) begin
			if (w.c16.funct3 == 3'b010 || w.c16.funct3 == 3'b110) begin
				r1 = 5'd2;
			end else begin
				r1 = w.c16.rd_rs1;
			end
		end
		if (w.c16.quadrant == 2'b10) begin
			r2 = w.c16.rs2;
		end else if (w.c16.quadrant != 2'b11) begin
			r2 = {2'b01, w.c16.rs2.prime};
		end
		return {r1, r2};
	endfunction

	// --------------------
	// bus model
	// accepts are sampled mid-cycle, ready and data change 1 ns after the edge
	initial begin : bus_model
		int delay;
		int due;
		mem_addr_rdy = 1'b0;
		mem_data     = '0;
		mem_data_vld = 1'b0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_addr_vld && mem_addr_rdy) begin
				// in-order return one to three cycles after the accept
				delay = 1 + ($unsigned($random(seed)) % 3);
				due   = cyc + delay;
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				bus_addr_q.push_back(mem_addr);
				bus_due_q.push_back(due);
				acc_log.push_back(mem_addr);
				if (bus_addr_q.size() > MAX_PENDING) begin
					$display("bus: %0d fetches outstanding, more than the front end may issue",
						bus_addr_q.size());
					err_count++;
				end
			end
			@(posedge clk);
			#1;
			cyc++;
			mem_addr_rdy = ($random(seed) & 3) != 0;
			mem_data_vld = 1'b0;
			if (!rst_n) begin
				bus_addr_q.delete();
				bus_due_q.delete();
			end else if (bus_due_q.size() > 0 && bus_due_q[0] <= cyc) begin
				mem_data     = read_word(bus_addr_q.pop_front());
				mem_data_vld = 1'b1;
				void'(bus_due_q.pop_front());
				returned++;
			end
		end
	end

	// --------------------
	// decode model
	always @(negedge clk) begin
		pd_sample <= {predecode_rs1, predecode_rs2};
	end

	always begin
		@(posedge clk);
		#1;
		cir_use = 2'd0;
		if (decode_en && got_q.size() < want && cir_vld != 2'd0) begin
			need_hw = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
			if (cir_vld >= need_hw) begin
				cir_use = need_hw;
				got_q.push_back((need_hw == 2'd2) ? cir : {16'h0, cir[15:0]});
				got_regs_q.push_back(pd_sample);
			end
		end
	end

	// --------------------
	// test helpers

	task automatic reset_dut();
		@(negedge clk);
		decode_en = 1'b0;
		want      = 0;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		got_q.delete();
		got_regs_q.delete();
		acc_log.delete();
		returned = 0;
		#1;
		rst_n = 1'b1;
	endtask

	task automatic start_decode(input int count);
		@(negedge clk);
		want      = count;
		decode_en = 1'b1;
	endtask

	task automatic run_until(input string name, input int count);
		int waited;
		waited = 0;
		while (got_q.size() < count && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (got_q.size() < count) begin
			$display("test %s: decode received only %0d of %0d instructions",
				name, got_q.size(), count);
			err_count++;
		end
	endtask

	task automatic check_stream(input string name, input int count);
		logic [9:0] regs;
		for (int i = 0; i < count && i < got_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				$display("Error %s: instruction %0d expected %h actual %h",
					name, i, exp_q[i], got_q[i]);
				err_count++;
			end
			regs = coarse_regs(exp_q[i]);
			if (got_regs_q[i] !== regs) begin
				$display("Error %s: predecode rs1/rs2 of instruction %0d expected %0d/%0d actual %0d/%0d",
					name, i, regs[9:5], regs[4:0], got_regs_q[i][9:5], got_regs_q[i][4:0]);
				err_count++;
			end
		end
	endtask

	task automatic finish_test(input string name, input int start_err);
		tests_run++;
		if (err_count != start_err) begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, err_count - start_err);
		end else begin
			$display("test %s: pass", name);
		end
	endtask

	// --------------------
	// directed tests

	task automatic test_reset_vector();
		int start_err;
		int waited;
		start_err = err_count;
		image.delete();
		reset_dut();
		@(negedge clk);
		if (jump_rdy !== 1'b1) begin
			$display("Error reset_vector: jump_rdy expected 1 actual %b", jump_rdy);
			err_count++;
		end
		waited = 0;
		while (returned == 0 && waited < WAIT_LIMIT) begin
			// no word has reached the bus yet, so the CIR must still be empty
			if (cir_vld !== 2'd0) begin
				$display("Error reset_vector: cir_vld expected 0 actual %0d", cir_vld);
				err_count++;
			end
			@(negedge clk);
			waited++;
		end
		if (acc_log.size() == 0) begin
			$display("test reset_vector: no fetch address was accepted after reset");
			err_count++;
		end else if (acc_log[0] !== RESET_VECTOR) begin
			$display("Error reset_vector: first address expected %h actual %h",
				RESET_VECTOR, acc_log[0]);
			err_count++;
		end
		finish_test("reset_vector", start_err);
	endtask

	task automatic test_stream(input string name, input int count, input int pct_c);
		int start_err;
		start_err = err_count;
		image.delete();
		exp_q.delete();
		place_program(RESET_VECTOR, count, pct_c);
		reset_dut();
		start_decode(count);
		run_until(name, count);
		check_stream(name, count);
		finish_test(name, start_err);
	endtask

	task automatic test_decode_stall();
		int start_err;
		start_err = err_count;
		image.delete();
		exp_q.delete();
		place_program(RESET_VECTOR, 40, 50);
		reset_dut();
		start_decode(40);
		run_until("decode_stall", 12);
		// the queue fills while decode holds, the bus model counts outstanding fetches
		decode_en = 1'b0;
		repeat (30) @(negedge clk);
		decode_en = 1'b1;
		run_until("decode_stall", 40);
		check_stream("decode_stall", 40);
		finish_test("decode_stall", start_err);
	endtask

	task automatic test_jump();
		int start_err;
		int waited;
		start_err = err_count;
		image.delete();
		exp_q.delete();
		place_program(JUMP_TARGET, 16, 50);
		tgt_q = exp_q;
		exp_q.delete();
		// a decoy in the low half of the target word must never reach decode
		write_half(JUMP_TARGET - 2, 16'h4505);
		place_program(RESET_VECTOR, 12, 50);
		reset_dut();
		start_decode(6);
		run_until("jump", 6);
		check_stream("jump", 6);
		decode_en = 1'b0;
		@(posedge clk);
		#1;
		jump_vld    = 1'b1;
		jump_target = JUMP_TARGET;
		waited      = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (jump_rdy !== 1'b1 && waited < WAIT_LIMIT);
		if (jump_rdy !== 1'b1) begin
			$display("test jump: the front end never accepted the jump");
			err_count++;
		end
		@(posedge clk);
		#1;
		jump_vld = 1'b0;
		@(negedge clk);
		if (cir_vld !== 2'd0) begin
			$display("Error jump: cir_vld after the jump expected 0 actual %0d", cir_vld);
			err_count++;
		end
		got_q.delete();
		got_regs_q.delete();
		exp_q = tgt_q;
		start_decode(exp_q.size());
		run_until("jump", exp_q.size());
		check_stream("jump", exp_q.size());
		finish_test("jump", start_err);
	endtask

	// --------------------
	// sequence and end of run

	initial begin
		rst_n       = 1'b0;
		jump_vld    = 1'b0;
		jump_target = '0;
		cir_use     = 2'd0;
		decode_en   = 1'b0;
		want        = 0;
		test_reset_vector();
		test_stream("word_stream", 32, 0);
		test_stream("mixed_stream", 48, 50);
		test_decode_stall();
		test_jump();
		$display("summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// the whole run is bounded by a fixed cycle budget per test
	initial begin
		repeat (N_TESTS * 400) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", N_TESTS * 400);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/fetch_pkg.sv
hw/fetch_request.sv
hw/prefetch_queue.sv
hw/instr_align.sv
hw/regnum_predecode.sv
hw/fetch_frontend.sv
dv/tb_fetch_frontend.sv

// ==== hw/fetch_frontend.sv ====
// instruction fetch front end top, joins request, queue, aligner and predecode
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic              clk,
	input  logic              rst_n,

	// instruction bus, word-sized word-aligned reads, data returns in order
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_addr_vld,
	input  logic              mem_addr_rdy,
	input  logic [W_DATA-1:0] mem_data,
	input  logic              mem_data_vld,

	// jump and flush
	input  logic [W_ADDR-1:0] jump_target,
	input  logic              jump_vld,
	output logic              jump_rdy,

	// decode
	output logic [W_DATA-1:0] cir,
	output hw_count_t         cir_vld,
	input  hw_count_t         cir_use,
	output logic [4:0]        predecode_rs1,
	output logic [4:0]        predecode_rs2
);

	// --------------------
	// internal connections
	logic              jump_now;
	hw_mask_t          data_hwvld;
	logic              data_live;
	logic [W_DATA-1:0] head_data;
	hw_mask_t          head_hwvld;
	logic              queue_empty;
	logic              queue_full;
	logic              queue_almost_full;
	logic              room;
	instr_word_u       next_instr;

	fetch_request #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_request (
		.clk              (clk),
		.rst_n            (rst_n),
		.jump_target      (jump_target),
		.jump_vld         (jump_vld),
		.jump_rdy         (jump_rdy),
		.jump_now         (jump_now),
		.mem_addr         (mem_addr),
		.mem_addr_vld     (mem_addr_vld),
		.mem_addr_rdy     (mem_addr_rdy),
		.mem_data_vld     (mem_data_vld),
		.queue_full       (queue_full),
		.queue_almost_full(queue_almost_full),
		.data_hwvld       (data_hwvld),
		.data_live        (data_live)
	);

	// queue and aligner both see the raw bus word, the aligner may bypass it
	prefetch_queue u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_data  (mem_data),
		.push_hwvld (data_hwvld),
		.data_live  (data_live),
		.jump_now   (jump_now),
		.room       (room),
		.head_data  (head_data),
		.head_hwvld (head_hwvld),
		.empty      (queue_empty),
		.full       (queue_full),
		.almost_full(queue_almost_full)
	);

	instr_align u_align (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_data  (head_data),
		.head_hwvld (head_hwvld),
		.queue_empty(queue_empty),
		.bus_data   (mem_data),
		.bus_hwvld  (data_hwvld),
		.data_live  (data_live),
		.jump_now   (jump_now),
		.cir_use    (cir_use),
		.cir        (cir),
		.cir_vld    (cir_vld),
		.room       (room),
		.next_instr (next_instr)
	);

	regnum_predecode u_predecode (
		.next_instr(next_instr),
		.rs1       (predecode_rs1),
		.rs2       (predecode_rs2)
	);

endmodule

// ==== hw/fetch_pkg.sv ====
// fetch front end shared widths, halfword counting types and the instruction word views
package fetch_pkg;

	// ------------------
	// bus and instruction widths
	localparam int unsigned W_ADDR = 32;
	localparam int unsigned W_DATA = 32;
	localparam int unsigned W_HALF = 16;

	// a two-entry queue is the smallest that keeps full fetch throughput
	// when decode stalls, given the registered pending count
	localparam int unsigned QUEUE_DEPTH = 2;
	localparam int unsigned MAX_PENDING = 2;

	// number of halfwords, 0 to 3 (cir_vld, cir_use, buffer level)
	typedef logic [1:0] hw_count_t;

	// per-halfword valid bits of one fetched word, bit 0 is the low halfword
	typedef logic [1:0] hw_mask_t;

	// 5-bit compressed register field, low three bits are the primed x8..x15 form
	typedef struct packed {
		logic [1:0] top;
		logic [2:0] prime;
	} creg_t;

	// ------------------
	// one instruction word, seen either as a full 32-bit instruction or as a
	// compressed instruction sitting in the low halfword
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [4:0] opcode;
			logic [1:0] quadrant;
		} i32;
		struct packed {
			logic [15:0] upper;
			logic [2:0]  funct3;
			logic        b12;
			creg_t       rd_rs1;
			creg_t       rs2;
			logic [1:0]  quadrant;
		} c16;
	} instr_word_u;

endpackage

// ==== hw/fetch_request.sv ====
// fetch request generator, issues word fetches, accepts jumps and tracks bus fetches in flight
`timescale 1ns/1ps

module fetch_request import fetch_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic              clk,
	input  logic              rst_n,

	// jump request from the core, taken when vld and rdy are both high
	input  logic [W_ADDR-1:0] jump_target,
	input  logic              jump_vld,
	output logic              jump_rdy,
	output logic              jump_now,

	// bus address phase and data return strobe
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_addr_vld,
	input  logic              mem_addr_rdy,
	input  logic              mem_data_vld,

	// prefetch queue fill state
	input  logic              queue_full,
	input  logic              queue_almost_full,

	// qualifiers for the word arriving on the bus this cycle
	output hw_mask_t          data_hwvld,
	output logic              data_live
);

	// fetch address runs ahead of the program counter in whole words
	logic [W_ADDR-1:0] fetch_addr;
	logic              addr_hold;
	logic [1:0]        pending;
	logic [1:0]        pending_next;
	logic [1:0]        flush_ctr;
	logic              first_odd;
	logic              fetch_stall;
	logic              jump_stall;
	logic              addr_accept;

	// --------------------
	// address phase

	// a held address phase must not change, so jumps wait for it to finish
	assign jump_rdy = !addr_hold;
	assign jump_now = jump_vld && jump_rdy;

	// the registered pending count keeps bus ready off the address path
	assign fetch_stall = queue_full
		|| (queue_almost_full && |pending)
		|| (pending >= 2'(MAX_PENDING));

	// a jump flushes the queue, so only the bus pipeline limits it
	assign jump_stall = pending >= 2'(MAX_PENDING);

	always_comb begin
		mem_addr     = fetch_addr;
		mem_addr_vld = 1'b1;
		if (addr_hold) begin
			// a held phase keeps the current address and stays valid
		end else if (jump_vld) begin
			// the target goes straight out, rounded down to its word
			mem_addr     = {jump_target[W_ADDR-1:2], 2'b00};
			mem_addr_vld = !jump_stall;
		end else begin
			mem_addr_vld = !fetch_stall;
		end
	end

	assign addr_accept  = mem_addr_vld && mem_addr_rdy;
	assign pending_next = pending + {1'b0, addr_accept} - {1'b0, mem_data_vld};

	// --------------------
	// data phase tracking

	// words still due for the old stream are dropped until the flush count drains
	assign data_live  = mem_data_vld && !(|flush_ctr) && !jump_now;
	assign data_hwvld = {1'b1, !first_odd};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= RESET_VECTOR;
			addr_hold  <= 1'b0;
			pending    <= 2'd0;
			flush_ctr  <= 2'd0;
			first_odd  <= 1'b0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending   <= pending_next;
			if (jump_now) begin
				// post-increment when the target address is accepted at once
				fetch_addr <= {jump_target[W_ADDR-1:2] + (W_ADDR-2)'(addr_accept), 2'b00};
			end else if (addr_accept) begin
				fetch_addr <= fetch_addr + W_ADDR'(4);
			end
			// everything in flight at the jump belongs to the old stream
			if (jump_now) begin
				flush_ctr <= pending - {1'b0, mem_data_vld};
			end else if (|flush_ctr && mem_data_vld) begin
				flush_ctr <= flush_ctr - 2'd1;
			end
			// first live word after a jump to an odd halfword loses its low half
			if (jump_now) begin
				first_odd <= jump_target[1];
			end else if (data_live) begin
				first_odd <= 1'b0;
			end
		end
	end

	// the stall terms must keep the bus pipeline within its limit
	a_pending_limit: assert property (@(posedge clk) disable iff (!rst_n)
		pending <= 2'(MAX_PENDING));

	// the bus only returns data for addresses it accepted earlier
	a_no_orphan_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_data_vld |-> pending != 2'd0);

endmodule

// ==== hw/instr_align.sv ====
// instruction aligner, assembles the CIR from queue or bus words and shifts out used halfwords
`timescale 1ns/1ps

module instr_align import fetch_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,

	// oldest queued word
	input  logic [W_DATA-1:0] head_data,
	input  hw_mask_t          head_hwvld,
	input  logic              queue_empty,

	// bus bypass path
	input  logic [W_DATA-1:0] bus_data,
	input  hw_mask_t          bus_hwvld,
	input  logic              data_live,
	input  logic              jump_now,

	// decode consumes halfwords in the same cycle it sees them
	input  hw_count_t         cir_use,
	output logic [W_DATA-1:0] cir,
	output hw_count_t         cir_vld,

	output logic              room,
	output instr_word_u       next_instr
);

	// level counts valid halfwords in {hwbuf, cir}
	logic [W_HALF-1:0]   hwbuf;
	hw_count_t           level;
	hw_count_t           level_no_fetch;
	hw_count_t           level_next;
	hw_count_t           fill_amount;
	logic [W_DATA-1:0]   fetch_data;
	logic [W_DATA-1:0]   fetch_aligned;
	hw_mask_t            fetch_hwvld;
	logic                fetch_vld;
	logic [3*W_HALF-1:0] store_shifted;
	logic [3*W_HALF-1:0] store_next;

	// --------------------
	// fetch source select

	// the bypass is only taken when nothing older waits in the queue
	assign fetch_data  = queue_empty ? bus_data : head_data;
	assign fetch_hwvld = queue_empty ? bus_hwvld : head_hwvld;
	assign fetch_vld   = !queue_empty || data_live;

	// a word holding only its upper halfword is moved down to the low half
	assign fetch_aligned = {
		fetch_data[W_DATA-1:W_HALF],
		fetch_hwvld[0] ? fetch_data[W_HALF-1:0] : fetch_data[W_DATA-1:W_HALF]
	};

	// --------------------
	// shift and overlay

	// halfwords above the new level are don't care, so reuse hwbuf there
	always_comb begin
		if (cir_use[1]) begin
			store_shifted = {hwbuf, cir[W_DATA-1:W_HALF], hwbuf};
		end else if (cir_use[0]) begin
			store_shifted = {hwbuf, hwbuf, cir[W_DATA-1:W_HALF]};
		end else begin
			store_shifted = {hwbuf, cir};
		end
	end

	assign level_no_fetch = level - cir_use;

	// a full word needs two free halfwords, a lone halfword needs one
	assign room = level_no_fetch <= ((&fetch_hwvld) ? 2'd1 : 2'd2);

	always_comb begin
		if (!room) begin
			store_next = store_shifted;
		end else if (level_no_fetch[1]) begin
			store_next = {fetch_aligned[W_HALF-1:0], store_shifted[2*W_HALF-1:0]};
		end else if (level_no_fetch[0]) begin
			store_next = {fetch_aligned, store_shifted[W_HALF-1:0]};
		end else begin
			store_next = {store_shifted[3*W_HALF-1:2*W_HALF], fetch_aligned};
		end
	end

	assign fill_amount = (room && fetch_vld) ? ((&fetch_hwvld) ? 2'd2 : 2'd1) : 2'd0;
	assign level_next  = jump_now ? 2'd0 : level_no_fetch + fill_amount;

	// predecode looks at what the CIR will hold after this edge
	assign next_instr = instr_word_u'(store_next[W_DATA-1:0]);

	// --------------------
	// state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= 2'd0;
			cir_vld <= 2'd0;
		end else begin
			level <= level_next;
			// decode only ever sees at most the two CIR halfwords
			cir_vld <= (level_next == 2'd3) ? 2'd2 : level_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= store_next;
	end

	// decode must not consume halfwords that are not there
	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld);

endmodule

// ==== hw/prefetch_queue.sv ====
// prefetch queue, a short shifting buffer of fetched words with per-halfword valid bits
`timescale 1ns/1ps

module prefetch_queue import fetch_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,

	// word arriving from the bus and its qualifiers
	input  logic [W_DATA-1:0] push_data,
	input  hw_mask_t          push_hwvld,
	input  logic              data_live,
	input  logic              jump_now,
	input  logic              room,

	// oldest entry and fill state
	output logic [W_DATA-1:0] head_data,
	output hw_mask_t          head_hwvld,
	output logic              empty,
	output logic              full,
	output logic              almost_full
);

	logic [W_DATA-1:0]      q_data [QUEUE_DEPTH];
	hw_mask_t               q_hw   [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] valid;
	logic [QUEUE_DEPTH-1:0] above_vld;
	logic [QUEUE_DEPTH-1:0] below_vld;
	logic                   push;
	logic                   pop;

	// neighbour indices clamped so every array select stays in range
	function automatic int unsigned up_idx(int unsigned i);
		return (i + 1 < QUEUE_DEPTH) ? i + 1 : i;
	endfunction

	function automatic int unsigned dn_idx(int unsigned i);
		return (i > 0) ? i - 1 : i;
	endfunction

	// a word bypassed straight into the CIR is not also written here
	assign pop  = room && valid[0];
	assign push = data_live && !(room && !valid[0]);

	always_comb begin
		for (int unsigned i = 0; i < QUEUE_DEPTH; i++) begin
			valid[i] = |q_hw[i];
		end
		for (int unsigned i = 0; i < QUEUE_DEPTH; i++) begin
			above_vld[i] = (i + 1 < QUEUE_DEPTH) && valid[up_idx(i)];
			below_vld[i] = (i == 0) || valid[dn_idx(i)];
		end
	end

	// --------------------
	// entries shift down on pop, fresh data lands in the lowest free slot
	always_ff @(posedge clk) begin
		for (int unsigned i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop || (push && !valid[i])) begin
				q_data[i] <= above_vld[i] ? q_data[up_idx(i)] : push_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int unsigned i = 0; i < QUEUE_DEPTH; i++) begin
				q_hw[i] <= '0;
			end
		end else begin
			for (int unsigned i = 0; i < QUEUE_DEPTH; i++) begin
				if (jump_now) begin
					q_hw[i] <= '0;
				end else if (above_vld[i] && pop) begin
					q_hw[i] <= q_hw[up_idx(i)];
				end else if (valid[i] && pop) begin
					q_hw[i] <= push ? push_hwvld : hw_mask_t'(0);
				end else if (valid[i]) begin
					q_hw[i] <= q_hw[i];
				end else if (push && !pop && below_vld[i]) begin
					q_hw[i] <= push_hwvld;
				end else begin
					q_hw[i] <= '0;
				end
			end
		end
	end

	assign head_data   = q_data[0];
	assign head_hwvld  = q_hw[0];
	assign empty       = !valid[0];
	assign full        = valid[QUEUE_DEPTH-1];
	assign almost_full = valid[QUEUE_DEPTH-2];

	// validity stays compact, so the head is always entry 0
	a_compact: assert property (@(posedge clk) disable iff (!rst_n)
		valid[QUEUE_DEPTH-1] |-> valid[0]);

	// the fetch stall terms never let a word arrive into a full queue
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		(push && !pop) |-> !full);

endmodule

// ==== hw/regnum_predecode.sv ====
// register number predecode, coarse rs1 and rs2 of the instruction entering the CIR
`timescale 1ns/1ps

module regnum_predecode import fetch_pkg::*; (
	input  instr_word_u next_instr,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2
);

	// stack pointer is implicit in addi4spn, lwsp and swsp
	localparam logic [4:0] REG_SP = 5'd2;

	// primed fields address x8 to x15
	localparam logic [1:0] PRIME_BASE = 2'b01;

	// coarse means the number is right whenever the operand is a real register,
	// and may be anything when the instruction does not read that port
	always_comb begin
		// 32-bit R, I, S and B formats keep rs1 and rs2 at fixed places
		rs1 = next_instr.i32.rs1;
		rs2 = next_instr.i32.rs2;
		if (next_instr.c16.quadrant != 2'b11) begin
			case (next_instr.c16.quadrant)
				2'b00: begin
					// addi4spn when the upper funct3 bits are clear, else loads and stores
					if (next_instr.c16.funct3[2:1] == 2'b00) begin
						rs1 = REG_SP;
					end else begin
						rs1 = {PRIME_BASE, next_instr.c16.rd_rs1.prime};
					end
				end
				2'b01: begin
					// addi and addi16sp use the full field, the rest don't care
					rs1 = next_instr.c16.rd_rs1;
				end
				default: begin
					// lwsp and swsp
					if (next_instr.c16.funct3[1:0] == 2'b10) begin
						rs1 = REG_SP;
					end else begin
						rs1 = next_instr.c16.rd_rs1;
					end
				end
			endcase
			// quadrant 2 carries a full rs2 (add, mv, swsp)
			if (next_instr.c16.quadrant == 2'b10) begin
				rs2 = next_instr.c16.rs2;
			end else begin
				rs2 = {PRIME_BASE, next_instr.c16.rs2.prime};
			end
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_fetch_frontend -Mdir "$BUILD_DIR" -o sim_fetch_frontend
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/sim_fetch_frontend" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
